/* hw/direction.hex */
// one 16-bit direction word per line, dim 0 to 3, gray bit 0 to 15 within each dim
8000
4000
2000
1000
0800
0400
0200
0100
0080
0040
0020
0010
0008
0004
0002
0001
8000
c000
a000
f000
8800
cc00
aa00
ff00
8080
c0c0
a0a0
f0f0
8888
cccc
aaaa
ffff
8000
c000
6000
9000
e800
5c00
8e00
c500
6880
9cc0
ee60
5590
8068
c09c
60ee
9055
8000
c000
2000
5000
f800
7400
a200
9300
d880
2540
59e0
e6d0
7808
b40c
8202
c305

/* sobol_path.f */
hw/sobol_pkg.sv
hw/sobol_req_if.sv
hw/path_sequencer.sv
hw/sobol_lane.sv
hw/sample_fifo.sv
hw/sobol_path_top.sv
testbench/sobol_path_checker.sv
testbench/sobol_path_tb.sv

/* Makefile */
TOP = sobol_path_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f sobol_path.f -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) +verilator+error+limit+1000 2>&1 | tee run.log
	grep -q "^Finished with no errors$$" run.log

clean:
	rm -rf obj_dir run.log

/* testbench/sobol_path_tb.sv */
`timescale 1ns/10ps

module sobol_path_tb import sobol_pkg::*; ();

    localparam int WAIT_LIMIT = 2000;    // cycles per wait loop

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   start;
    logic [SOBOL_WIDTH-1:0] path_count;
    logic                   sample_ready;
    logic                   busy;
    logic                   sample_valid;
    logic [SOBOL_WIDTH-1:0] sample_value;
    logic [SOBOL_WIDTH-1:0] sample_idx;
    logic [DIM_W-1:0]       sample_dim;

    logic [SOBOL_WIDTH-1:0] dir_tab [0:NUM_DIMS*SOBOL_WIDTH-1];
    logic [31:0]            rng = 32'hd024;
    logic                   random_ready = 1'b0;

    // expected position in path-major order
    logic [SOBOL_WIDTH-1:0] exp_idx = '0;
    int                     exp_dim = 0;
    logic [SOBOL_WIDTH-1:0] want_value;
    int                     rx_count = 0;

    int errors       = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int err_mark     = 0;

    sobol_path_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .path_count   (path_count),
        .sample_ready (sample_ready),
        .busy         (busy),
        .sample_valid (sample_valid),
        .sample_value (sample_value),
        .sample_idx   (sample_idx),
        .sample_dim   (sample_dim)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // xor of the direction words picked by the gray code of idx
    function automatic logic [SOBOL_WIDTH-1:0] sobol_model(input logic [SOBOL_WIDTH-1:0] idx,
                                                        input int dim);
        logic [SOBOL_WIDTH-1:0] gray;
        logic [SOBOL_WIDTH-1:0] acc;
        gray = idx ^ (idx >> 1);
        acc  = '0;
        for (int k = 0; k < SOBOL_WIDTH; k++) begin
            if (gray[k]) begin
                acc = acc ^ dir_tab[dim * SOBOL_WIDTH + k];
            end
        end
        return acc;
    endfunction

    function automatic int total_errors();
        return errors + dut_i.checker_i.assert_fails;
    endfunction

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        $display("error at %0d ns: %s is %h, expected %h", $time, name, got, want);
        errors++;
    endtask

    always @(negedge clk) begin
        if (random_ready) begin
            rng = xorshift32(rng);
            sample_ready = (rng[1:0] != 2'b00);     // high about 3 cycles in 4
        end else begin
            sample_ready = 1'b1;
        end
    end

    // every output transfer is compared with the model
    always @(posedge clk) begin
        if (rst_n && sample_valid && sample_ready) begin
            want_value = sobol_model(exp_idx, exp_dim);
            assert (sample_idx == exp_idx)
                else report_value("sample_idx", 32'(sample_idx), 32'(exp_idx));
            assert (sample_dim == DIM_W'(exp_dim))
                else report_value("sample_dim", 32'(sample_dim), 32'(exp_dim));
            assert (sample_value == want_value)
                else report_value("sample_value", 32'(sample_value), 32'(want_value));
            rx_count++;
            if (exp_dim == NUM_DIMS - 1) begin
                exp_dim = 0;
                exp_idx = exp_idx + 1'b1;
            end else begin
                exp_dim++;
            end
        end
    end

    task automatic begin_test(input logic rand_mode);
        @(posedge clk);
        random_ready = rand_mode;    // picked up by the next falling edge
        @(negedge clk);
        rx_count     = 0;
        exp_idx      = '0;
        exp_dim      = 0;
        err_mark     = total_errors();
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (total_errors() == err_mark) begin
            $display("test %s: ok, %0d samples", name, rx_count);
        end else begin
            tests_failed++;
            $display("test %s: FAILED, %0d samples", name, rx_count);
        end
    endtask

    task automatic pulse_start(input int paths);
        @(negedge clk);
        start      = 1'b1;
        path_count = SOBOL_WIDTH'(paths);
        @(negedge clk);
        start      = 1'b0;
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (busy && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (busy) begin
            $display("timeout: busy still high after %0d cycles", WAIT_LIMIT);
            errors++;
        end
    endtask

    task automatic wait_samples(input int target);
        int cycles;
        cycles = 0;
        while (rx_count < target && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (rx_count < target) begin
            $display("timeout: only %0d of %0d samples arrived", rx_count, target);
            errors++;
        end
    endtask

    // nothing extra may trail the expected samples
    task automatic check_drained(input int target);
        repeat (6) @(negedge clk);
        assert (rx_count == target)
            else report_value("rx_count", 32'(rx_count), 32'(target));
        assert (!sample_valid)
            else report_value("sample_valid", 32'(sample_valid), 32'(0));
    endtask

    task automatic run_paths(input string name, input int paths, input logic rand_mode);
        begin_test(rand_mode);
        pulse_start(paths);
        wait_idle();
        wait_samples(paths * NUM_DIMS);
        check_drained(paths * NUM_DIMS);
        end_test(name);
    endtask

    initial begin
        rst_n        = 1'b0;
        start        = 1'b0;
        path_count   = '0;
        sample_ready = 1'b0;
        $readmemh("hw/direction.hex", dir_tab);
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        // idle after reset with no start
        begin_test(1'b0);
        repeat (10) begin
            @(negedge clk);
            assert (!busy) else report_value("busy", 32'(busy), 32'(0));
            assert (!sample_valid)
                else report_value("sample_valid", 32'(sample_valid), 32'(0));
        end
        end_test("reset_idle");

        run_paths("single_path", 1, 1'b0);
        run_paths("twenty_paths", 20, 1'b0);
        run_paths("random_ready", 20, 1'b1);

        // restart while busy is ignored and a zero count does nothing
        begin_test(1'b0);
        pulse_start(3);
        repeat (2) @(negedge clk);
        pulse_start(7);
        wait_idle();
        wait_samples(3 * NUM_DIMS);
        check_drained(3 * NUM_DIMS);
        pulse_start(0);
        repeat (10) begin
            @(negedge clk);
            assert (!busy) else report_value("busy", 32'(busy), 32'(0));
        end
        assert (rx_count == 3 * NUM_DIMS)
            else report_value("rx_count", 32'(rx_count), 32'(3 * NUM_DIMS));
        end_test("ignored_starts");

        run_paths("after_ignored", 2, 1'b0);

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, total_errors());
        if (total_errors() == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* testbench/sobol_path_checker.sv */
`timescale 1ns/10ps

// protocol checks on the top-level sample port and busy flag
module sobol_path_checker import sobol_pkg::*; (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   start,
    input logic                   busy,
    input logic                   sample_valid,
    input logic                   sample_ready,
    input logic [SOBOL_WIDTH-1:0] sample_value,
    input logic [SOBOL_WIDTH-1:0] sample_idx,
    input logic [DIM_W-1:0]       sample_dim
);

    int assert_fails = 0;   // failed assertions so far

    // a stalled sample must not change under the consumer
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid && !sample_ready |=>
            sample_valid && $stable(sample_value) && $stable(sample_idx) && $stable(sample_dim))
        else begin
            $error("sample changed while stalled");
            assert_fails++;
        end

    a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(sample_valid))
        else begin
            $error("sample_valid is unknown");
            assert_fails++;
        end

    // busy only comes up one cycle after a start pulse
    a_busy_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(busy) |-> $past(start))
        else begin
            $error("busy rose without a start");
            assert_fails++;
        end

endmodule

bind sobol_path_top sobol_path_checker checker_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .busy         (busy),
    .sample_valid (sample_valid),
    .sample_ready (sample_ready),
    .sample_value (sample_value),
    .sample_idx   (sample_idx),
    .sample_dim   (sample_dim)
);

/* hw/sobol_path_top.sv */
`timescale 1ns/10ps

module sobol_path_top import sobol_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic [SOBOL_WIDTH-1:0] path_count,
    input  logic                   sample_ready,
    output logic                   busy,
    output logic                   sample_valid,
    output logic [SOBOL_WIDTH-1:0] sample_value,
    output logic [SOBOL_WIDTH-1:0] sample_idx,
    output logic [DIM_W-1:0]       sample_dim
);

    sobol_req_if req_if ();

    logic    lane_valid;
    logic    lane_ready;
    sample_t lane_sample;
    sample_t fifo_sample;

    path_sequencer u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .path_count (path_count),
        .busy       (busy),
        .req        (req_if.source)
    );

    sobol_lane u_lane (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req_if.sink),
        .out_valid  (lane_valid),
        .out_ready  (lane_ready),
        .out_sample (lane_sample)
    );

    sample_fifo u_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (lane_valid),
        .in_ready   (lane_ready),
        .in_sample  (lane_sample),
        .out_valid  (sample_valid),
        .out_ready  (sample_ready),
        .out_sample (fifo_sample)
    );

    // head of the fifo onto the flat output ports
    assign sample_value = fifo_sample.value;
    assign sample_idx   = fifo_sample.idx;
    assign sample_dim   = fifo_sample.dim;

endmodule

/* hw/sample_fifo.sv */
`timescale 1ns/10ps

module sample_fifo import sobol_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid,
    output logic    in_ready,
    input  sample_t in_sample,
    output logic    out_valid,
    input  logic    out_ready,
    output sample_t out_sample
);

    sample_t          mem [0:FIFO_DEPTH-1];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic full;
    logic wr_en;
    logic rd_en;

    assign full      = (count == CNT_W'(FIFO_DEPTH));
    assign out_valid = (count != '0);
    assign out_sample = mem[rd_ptr];     // head entry

    // when full, a read in the same cycle frees the slot being written
    assign in_ready  = !full || out_ready;

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + PTR_W'(1);    // depth is a power of two
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_sample;
        end
    end

endmodule

/* hw/sobol_lane.sv */
`timescale 1ns/10ps

module sobol_lane import sobol_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    sobol_req_if.sink req,
    output logic      out_valid,
    input  logic      out_ready,
    output sample_t   out_sample
);

    // direction numbers, NUM_DIMS blocks of SOBOL_WIDTH words
    logic [SOBOL_WIDTH-1:0] direction [0:DIR_WORDS-1];

    initial begin
        $readmemh(DIRECTION_FILE, direction);
    end

    logic [SOBOL_WIDTH-1:0] gray;
    logic [SOBOL_WIDTH-1:0] tree [0:TREE_NODES-1];
    logic                   hold_valid;
    sample_t                hold_sample;
    logic                   accept;

    // successive gray codes differ in one bit, so each new point
    // flips a single direction word relative to the previous one
    assign gray = req.idx ^ (req.idx >> 1);

    // leaves: direction word for each set gray bit, zero otherwise
    for (genvar k = 0; k < SOBOL_WIDTH; k++) begin : g_leaf
        assign tree[SOBOL_WIDTH - 1 + k] =
            gray[k] ? direction[int'(req.dim) * SOBOL_WIDTH + k] : '0;
    end

    // inner nodes combine their two children, log2(SOBOL_WIDTH) levels deep
    for (genvar n = 0; n < SOBOL_WIDTH - 1; n++) begin : g_node
        assign tree[n] = tree[2*n + 1] ^ tree[2*n + 2];
    end

    // take a new request when the register is empty or draining this cycle
    assign req.ready  = !hold_valid || out_ready;
    assign accept     = req.valid && req.ready;

    assign out_valid  = hold_valid;
    assign out_sample = hold_sample;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_valid <= 1'b0;
        end else if (accept) begin
            hold_valid <= 1'b1;
        end else if (out_ready) begin
            hold_valid <= 1'b0;          // drained with nothing behind it
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            hold_sample.value <= tree[0];
            hold_sample.idx   <= req.idx;    // tag travels with the value
            hold_sample.dim   <= req.dim;
        end
    end

endmodule

/* hw/path_sequencer.sv */
`timescale 1ns/10ps

module path_sequencer import sobol_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic [SOBOL_WIDTH-1:0] path_count,
    output logic                   busy,
    sobol_req_if.source            req
);

    seq_state_t             state;
    logic [SOBOL_WIDTH-1:0] idx_cnt;
    logic [DIM_W-1:0]       dim_cnt;
    logic [SOBOL_WIDTH-1:0] count_q;    // path count latched at start

    logic accept;
    logic last_dim;
    logic last_idx;

    assign accept   = req.valid && req.ready;
    assign last_dim = (dim_cnt == DIM_W'(NUM_DIMS - 1));
    assign last_idx = (idx_cnt == count_q - SOBOL_WIDTH'(1));

    // request stays up for the whole run, idx/dim only move on accept
    assign busy      = (state == SEQ_RUN);
    assign req.valid = (state == SEQ_RUN);
    assign req.idx   = idx_cnt;
    assign req.dim   = dim_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= SEQ_IDLE;
            idx_cnt <= '0;
            dim_cnt <= '0;
            count_q <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    // zero paths means nothing to do
                    if (start && (path_count != '0)) begin
                        state   <= SEQ_RUN;
                        count_q <= path_count;
                        idx_cnt <= '0;
                        dim_cnt <= '0;
                    end
                end
                SEQ_RUN: begin
                    // start is ignored here
                    if (accept) begin
                        if (last_dim) begin
                            dim_cnt <= '0;
                            if (last_idx) begin
                                state <= SEQ_IDLE;          // final request taken
                            end else begin
                                idx_cnt <= idx_cnt + SOBOL_WIDTH'(1);
                            end
                        end else begin
                            dim_cnt <= dim_cnt + DIM_W'(1);
                        end
                    end
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

endmodule

/* hw/sobol_req_if.sv */
`timescale 1ns/10ps

// request stream from the path sequencer into the sobol lane
interface sobol_req_if import sobol_pkg::*; ();

    logic                   valid;
    logic                   ready;
    logic [SOBOL_WIDTH-1:0] idx;   // path index
    logic [DIM_W-1:0]       dim;   // time-step within the path

    modport source (
        output valid,
        output idx,
        output dim,
        input  ready
    );

    modport sink (
        input  valid,
        input  idx,
        input  dim,
        output ready
    );

endinterface

/* hw/sobol_pkg.sv */
package sobol_pkg;

    // sobol value and path index share one width
    localparam int SOBOL_WIDTH = 16;
    localparam int NUM_DIMS    = 4;                   // time-steps per path
    localparam int DIM_W       = $clog2(NUM_DIMS);

    localparam int FIFO_DEPTH  = 8;
    localparam int PTR_W       = $clog2(FIFO_DEPTH);
    localparam int CNT_W       = $clog2(FIFO_DEPTH + 1);

    // direction table holds one word per (dim, gray bit)
    localparam int DIR_WORDS   = NUM_DIMS * SOBOL_WIDTH;

    // xor tree kept as a heap: leaves at the back, root at node 0
    localparam int TREE_NODES  = 2 * SOBOL_WIDTH - 1;

    localparam string DIRECTION_FILE = "hw/direction.hex";

    typedef struct packed {
        logic [SOBOL_WIDTH-1:0] value;
        logic [SOBOL_WIDTH-1:0] idx;
        logic [DIM_W-1:0]       dim;
    } sample_t;

    typedef enum logic {
        SEQ_IDLE,
        SEQ_RUN
    } seq_state_t;

endpackage
